// ==== all.f ====
design/cpuPkg.sv
design/fetchStage.sv
design/decodeControl.sv
design/regFile.sv
design/issueStage.sv
design/executeCommit.sv
design/pipeCore.sv
testbench/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module coreTb \
    -f all.f \
    --Mdir obj_dir \
    -o coreSim

./obj_dir/coreSim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/coreTb.sv ====
`timescale 1ns/1ns

module coreTb;
    import cpuPkg::*;

    localparam logic [31:0] resetPc  = 32'h0000_0100;
    localparam int          memWords = 256;
    localparam int          maxExp   = 512;
    localparam int          timeout  = 3000;   // cycles per test

    logic        clk = 1'b0;
    logic        nrst;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic [31:0] memIdx;
    wbPort_s     wb;

    logic [31:0] progMem [memWords];
    int          progLen;
    logic [4:0]  expAddr [maxExp];    // expected writes in program order
    logic [31:0] expData [maxExp];
    logic [31:0] expPc   [maxExp];    // pc of the writing instruction
    logic [31:0] expFetch [2*maxExp]; // fetch order including the wrong path
    int          expCount;
    int          expIdx;
    int          fetchCount;
    int          fetchIdx;
    logic [31:0] addrHist [5];        // instrAddr of the last five cycles
    int          errors;
    int          testsRun;
    int          testsFailed;

    pipeCore #(.resetPc(resetPc)) DUT (
        .clk       (clk),
        .nrst      (nrst),
        .instr     (instr),
        .instrAddr (instrAddr),
        .wb        (wb)
    );

    always #2 clk = ~clk;

    // same cycle instruction memory
    assign memIdx = (instrAddr - resetPc) >> 2;
    assign instr  = (instrAddr >= resetPc && memIdx < memWords) ? progMem[memIdx[7:0]]
                                                                 : nopWord;

    always @(posedge clk)
    begin
        addrHist[0] <= instrAddr;
        for (int i = 1; i < 5; i++)
            addrHist[i] <= addrHist[i-1];
        if (!nrst)
        begin
            fetchIdx <= 0;
            expIdx   <= 0;
        end
        else
        begin
            fetchIdx <= fetchIdx + 1;
            if (wb.valid)
                expIdx <= expIdx + 1; // head of the write list moves on
        end
    end

    task automatic checkFail(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // checks sample on the falling edge where DUT outputs are settled
    resetQuiet: assert property (@(negedge clk) !nrst |-> (!wb.valid && instrAddr == resetPc))
        else checkFail($sformatf("in reset wbValid %b instrAddr %h", wb.valid, instrAddr));

    wbOrder: assert property (@(negedge clk) (nrst && wb.valid) |->
        (expIdx < expCount && wb.addr == expAddr[expIdx] && wb.data == expData[expIdx]))
        else checkFail($sformatf("write x%0d=%h, expected #%0d of %0d x%0d=%h", wb.addr,
                                 wb.data, expIdx, expCount, expAddr[expIdx], expData[expIdx]));

    wbLatency: assert property (@(negedge clk) (nrst && wb.valid && expIdx < expCount) |->
        addrHist[4] == expPc[expIdx])
        else checkFail($sformatf("write x%0d came 5 cycles after fetch of %h, not %h",
                                 wb.addr, addrHist[4], expPc[expIdx]));

    x0Silent: assert property (@(negedge clk) wb.valid |-> wb.addr != 5'd0)
        else checkFail("wbValid raised for x0");

    fetchOrder: assert property (@(negedge clk) (nrst && fetchIdx < fetchCount) |->
        instrAddr == expFetch[fetchIdx])
        else checkFail($sformatf("fetch #%0d at %h, expected %h", fetchIdx, instrAddr,
                                 expFetch[fetchIdx]));

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    task automatic put(input logic [31:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic emit(input logic [31:0] w);
        put(w);
        put(nopWord); // two nops keep dependent pairs apart
        put(nopWord);
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit({hi[19:0], rd, opLui});
        emit(encI(value[11:0], rd, 3'b000, rd, opOpImm));
    endtask

    // k extra sentinel slots past the three squashed ones
    task automatic putSentinels(input int k);
        for (int i = 0; i < 3 + k; i++)
            put(encI($urandom_range(4095), 5'd0, 3'b000, 5'($urandom_range(31, 4)), opOpImm));
        put(nopWord);
        put(nopWord);
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
        input logic isOp, input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return (isOp && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // sequential ISA model that builds the write list and the fetch order
    task automatic runModel();
        logic [31:0] m [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] target;
        logic [31:0] immI;
        logic        wr;
        logic        taken;
        for (int i = 0; i < 32; i++)
            m[i] = '0;
        pc         = resetPc;
        expCount   = 0;
        fetchCount = 0;
        for (int step = 0; step < 4000; step++)
        begin
            w     = progMem[(pc - resetPc) >> 2];
            a     = m[w[19:15]];
            b     = m[w[24:20]];
            immI  = {{20{w[31]}}, w[31:20]};
            wr    = 1'b0;
            taken = 1'b0;
            res   = '0;
            expFetch[fetchCount] = pc;
            fetchCount++;
            case (w[6:0])
                opOp:
                begin
                    res = aluRef(w[14:12], w[30], 1'b1, a, b);
                    wr  = 1'b1;
                end
                opOpImm:
                begin
                    b   = (w[14:12] == 3'd1 || w[14:12] == 3'd5) ? {27'b0, w[24:20]} : immI;
                    res = aluRef(w[14:12], w[30], 1'b0, a, b);
                    wr  = 1'b1;
                end
                opLui:
                begin
                    res = {w[31:12], 12'b0};
                    wr  = 1'b1;
                end
                opBranch:
                begin
                    taken  = (w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b);
                    target = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
                opJal:
                begin
                    res    = pc + 4;
                    wr     = 1'b1;
                    taken  = 1'b1;
                    target = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                opJalr:
                begin
                    res    = pc + 4;
                    wr     = 1'b1;
                    taken  = 1'b1;
                    target = (a + immI) & ~32'd1;
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0)
            begin
                m[w[11:7]] = res;
                expAddr[expCount] = w[11:7];
                expData[expCount] = res;
                expPc[expCount]   = pc;
                expCount++;
            end
            if (taken)
            begin
                for (int i = 1; i <= 3; i++)
                begin
                    expFetch[fetchCount] = pc + 4 * i; // squashed fetches
                    fetchCount++;
                end
                if (target == pc)
                begin
                    expFetch[fetchCount] = pc; // halt loop
                    fetchCount++;
                    break;
                end
                pc = target;
            end
            else
                pc = pc + 4;
        end
    endtask

    task automatic beginTest();
        @(posedge clk);
        #1 nrst = 1'b0;
        progLen = 0;
        for (int i = 0; i < memWords; i++)
            progMem[i] = encI(12'(i), 5'd0, 3'b000, 5'd0, opOpImm); // addi x0 with the word index
    endtask

    task automatic finishTest(input string name);
        int errorsBefore;
        int cycles;
        errorsBefore = errors;
        put(encJ(21'd0, 5'd0)); // jal x0, 0 halts
        runModel();
        repeat (8) @(posedge clk);
        #1 nrst = 1'b1;
        cycles = 0;
        while ((expIdx < expCount || fetchIdx < fetchCount) && cycles < timeout)
        begin
            @(posedge clk);
            #1 cycles++;
        end
        if (cycles >= timeout)
        begin
            $display("test %s timed out after %0d cycles with %0d of %0d writes seen",
                     name, cycles, expIdx, expCount);
            errors++;
        end
        repeat (8) @(posedge clk); // stray commits would show here
        testsRun++;
        if (errors != errorsBefore)
            testsFailed++;
        $display("test %-8s %s  (%0d writes)", name,
                 (errors == errorsBefore) ? "passed" : "failed", expCount);
    endtask

    task automatic testReset();
        beginTest();
        loadConst(5'd1, $urandom);
        emit(encI($urandom_range(4095), 5'd1, 3'b000, 5'd2, opOpImm));
        finishTest("reset");
    endtask

    task automatic testArith();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        beginTest();
        for (int r = 1; r <= 6; r++)
            loadConst(5'(r), $urandom);
        for (int i = 0; i < 24; i++)
        begin
            rd  = 5'($urandom_range(31, 1));
            rs1 = 5'($urandom_range(31, 1));
            rs2 = 5'($urandom_range(31, 1));
            case ($urandom_range(8))
                0: emit(encR(7'h00, rs2, rs1, 3'd0, rd));  // add
                1: emit(encR(7'h20, rs2, rs1, 3'd0, rd));  // sub
                2: emit(encR(7'h00, rs2, rs1, 3'd7, rd));
                3: emit(encR(7'h00, rs2, rs1, 3'd6, rd));
                4: emit(encR(7'h00, rs2, rs1, 3'd4, rd));
                5: emit(encR(7'h00, rs2, rs1, 3'd2, rd));  // slt
                6: emit(encR(7'h00, rs2, rs1, 3'd3, rd));  // sltu
                7: emit(encI($urandom_range(4095), rs1, 3'd0, rd, opOpImm));
                default: emit({20'($urandom), rd, opLui});
            endcase
        end
        finishTest("arith");
    endtask

    task automatic testShift();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] sh;
        beginTest();
        for (int r = 1; r <= 5; r++)
            loadConst(5'(r), $urandom);
        for (int i = 0; i < 24; i++)
        begin
            rd  = 5'($urandom_range(31, 1));
            rs1 = 5'($urandom_range(31, 1));
            rs2 = 5'($urandom_range(31, 1));
            sh  = 5'($urandom_range(31));
            case ($urandom_range(5))
                0: emit(encI({7'h00, sh}, rs1, 3'd1, rd, opOpImm)); // slli
                1: emit(encI({7'h00, sh}, rs1, 3'd5, rd, opOpImm)); // srli
                2: emit(encI({7'h20, sh}, rs1, 3'd5, rd, opOpImm)); // srai
                3: emit(encR(7'h00, rs2, rs1, 3'd1, rd));
                4: emit(encR(7'h00, rs2, rs1, 3'd5, rd));
                default: emit(encR(7'h20, rs2, rs1, 3'd5, rd));
            endcase
        end
        finishTest("shift");
    endtask

    task automatic testBranch();
        int k;
        beginTest();
        loadConst(5'd1, $urandom);
        loadConst(5'd2, $urandom);
        emit(encI(12'd0, 5'd1, 3'd0, 5'd3, opOpImm)); // x3 copies x1
        for (int i = 0; i < 12; i++)
        begin
            k = $urandom_range(2);
            put(encB(13'(16 + 4 * k), 5'($urandom_range(3, 1)), 5'($urandom_range(3, 1)),
                     3'($urandom_range(1))));
            putSentinels(k);
        end
        finishTest("branch");
    endtask

    task automatic testJump();
        int          k;
        logic [4:0]  base;
        logic [31:0] jalrPc;
        logic [31:0] imm;
        beginTest();
        for (int i = 0; i < 8; i++)
        begin
            k = $urandom_range(2);
            put(encJ(21'(16 + 4 * k), 5'($urandom_range(31))));
            putSentinels(k);
            k      = $urandom_range(2);
            base   = 5'($urandom_range(31, 1));
            jalrPc = resetPc + 4 * (progLen + 6); // after the six word loadConst
            imm    = 32'($urandom_range(127)) - 32'd64;
            loadConst(base, jalrPc + 16 + 4 * k - imm + $urandom_range(1)); // bit 0 cleared
            put(encI(imm[11:0], base, 3'd0, 5'($urandom_range(31)), opJalr));
            putSentinels(k);
        end
        finishTest("jump");
    endtask

    task automatic testZero();
        beginTest();
        loadConst(5'd1, $urandom);
        loadConst(5'd2, $urandom);
        emit(encI($urandom_range(4095, 1), 5'd1, 3'd0, 5'd0, opOpImm));
        emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        emit({20'($urandom), 5'd0, opLui});
        emit(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));   // reads zero back
        emit(encR(7'h00, 5'd0, 5'd1, 3'd6, 5'd6));
        emit(encI($urandom_range(4095), 5'd0, 3'd0, 5'd7, opOpImm));
        finishTest("x0");
    endtask

    initial
    begin
        void'($urandom(32'h1d0dc5ec));
        nrst        = 1'b0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        progLen     = 0;
        expCount    = 0;
        fetchCount  = 0;
        for (int i = 0; i < memWords; i++)
            progMem[i] = nopWord;
        testReset();
        testArith();
        testShift();
        testBranch();
        testJump();
        testZero();
        $display("tests %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== design/pipeCore.sv ====
`timescale 1ns/1ns

module pipeCore #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic [31:0]     instr,     // instruction memory read data
    output logic [31:0]     instrAddr,
    output cpuPkg::wbPort_s wb         // commit port, also the regfile write
);
    import cpuPkg::*;

    instrWord_u instrD;
    logic [31:0] pcD;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    issueCtrl_s  ctrl3;
    exeCtrl_s    ctrl4;
    redirect_s   redirect;  // decided in execute only

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk       (clk),
        .nrst      (nrst),
        .redirect  (redirect),
        .instr     (instr),
        .instrAddr (instrAddr),
        .instrD    (instrD),
        .pcD       (pcD)
    );

    decodeControl decode (
        .clk      (clk),
        .nrst     (nrst),
        .instrD   (instrD),
        .pcD      (pcD),
        .redirect (redirect),
        .rs1      (rs1),
        .rs2      (rs2),
        .ctrl3    (ctrl3)
    );

    issueStage issue (
        .clk      (clk),
        .nrst     (nrst),
        .rs1      (rs1),
        .rs2      (rs2),
        .ctrl3    (ctrl3),
        .redirect (redirect),
        .wb       (wb),
        .ctrl4    (ctrl4)
    );

    executeCommit execute (
        .clk      (clk),
        .nrst     (nrst),
        .ctrl4    (ctrl4),
        .redirect (redirect),
        .wb       (wb)
    );

endmodule

// ==== design/executeCommit.sv ====
`timescale 1ns/1ns

module executeCommit (
    input  logic              clk,
    input  logic              nrst,
    input  cpuPkg::exeCtrl_s  ctrl4,
    output cpuPkg::redirect_s redirect, // comb from pipe #4
    output cpuPkg::wbPort_s   wb        // pipe #6
);
    import cpuPkg::*;

    logic [31:0] aluOut;
    logic [31:0] result;
    logic        brTaken;
    wbPort_s     res5;     // pipe #5
    wbPort_s     nextRes;

    always_comb
    begin
        case (ctrl4.aluFn)
            aluAdd:   aluOut = ctrl4.opA + ctrl4.opB;
            aluSub:   aluOut = ctrl4.opA - ctrl4.opB;
            aluAnd:   aluOut = ctrl4.opA & ctrl4.opB;
            aluOr:    aluOut = ctrl4.opA | ctrl4.opB;
            aluXor:   aluOut = ctrl4.opA ^ ctrl4.opB;
            aluSlt:   aluOut = {31'b0, $signed(ctrl4.opA) < $signed(ctrl4.opB)};
            aluSltu:  aluOut = {31'b0, ctrl4.opA < ctrl4.opB};
            aluSll:   aluOut = ctrl4.opA << ctrl4.opB[4:0];
            aluSrl:   aluOut = ctrl4.opA >> ctrl4.opB[4:0];
            aluSra:   aluOut = $unsigned($signed(ctrl4.opA) >>> ctrl4.opB[4:0]);
            aluPassB: aluOut = ctrl4.opB; // lui
            default:  aluOut = ctrl4.opA + ctrl4.opB;
        endcase
    end

    assign result = ctrl4.linkSel ? ctrl4.pc + 32'd4 : aluOut; // jal and jalr link

    // beq when equal and bne when not
    assign brTaken = ctrl4.isBranch &&
                     (ctrl4.bneq ? (ctrl4.opA != ctrl4.opB) : (ctrl4.opA == ctrl4.opB));

    assign redirect.taken = brTaken | ctrl4.j | ctrl4.jr;

    always_comb
    begin
        if (ctrl4.jr)
            redirect.target = (ctrl4.opA + ctrl4.opB) & ~32'd1; // opB is immI
        else if (ctrl4.j)
            redirect.target = ctrl4.pc + ctrl4.immJ;
        else
            redirect.target = ctrl4.pc + ctrl4.immB;
    end

    assign nextRes.valid = ctrl4.we;
    assign nextRes.addr  = ctrl4.rd;
    assign nextRes.data  = result;

    // pipe #5 then pipe #6
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            res5 <= '0;
            wb   <= '0;
        end
        else
        begin
            res5 <= nextRes;
            wb   <= res5;
        end
    end

    targetAligned: assert property (@(posedge clk) disable iff (!nrst)
        redirect.taken |-> redirect.target[1:0] == 2'b00)
        else $error("redirect target %h not word aligned", redirect.target);

    // jalr relies on decode steering immI into opB
    jalrUsesImm: assert property (@(posedge clk) disable iff (!nrst)
        ctrl4.jr |-> ctrl4.bSel == bImmI)
        else $error("jalr reached execute without immI on opB");

endmodule

// ==== design/issueStage.sv ====
`timescale 1ns/1ns

module issueStage (
    input  logic               clk,
    input  logic               nrst,
    input  logic [4:0]         rs1,      // addresses of the pipe #2 word
    input  logic [4:0]         rs2,
    input  cpuPkg::issueCtrl_s ctrl3,
    input  cpuPkg::redirect_s  redirect,
    input  cpuPkg::wbPort_s    wb,       // from pipe #6
    output cpuPkg::exeCtrl_s   ctrl4     // pipe #4
);
    import cpuPkg::*;

    logic [31:0] rdA;
    logic [31:0] rdB;
    logic [31:0] opB;
    exeCtrl_s    nextCtrl;

    // read addresses are held one cycle inside so data lines up with ctrl3
    regFile regs (
        .clk  (clk),
        .nrst (nrst),
        .wb   (wb),
        .rs1  (rs1),
        .rs2  (rs2),
        .rdA  (rdA),
        .rdB  (rdB)
    );

    // operand b mux
    always_comb
    begin
        unique case (ctrl3.bSel)
            bRegB:   opB = rdB;
            bImmI:   opB = ctrl3.immI;
            bShamt:  opB = {27'b0, ctrl3.shamt}; // shift amount zero extended
            default: opB = rdB;
        endcase
    end

    always_comb
    begin
        nextCtrl.we       = ctrl3.we;
        nextCtrl.linkSel  = ctrl3.linkSel;
        nextCtrl.isBranch = ctrl3.isBranch;
        nextCtrl.bneq     = ctrl3.bneq;
        nextCtrl.j        = ctrl3.j;
        nextCtrl.jr       = ctrl3.jr;
        nextCtrl.aluFn    = ctrl3.aluFn;
        nextCtrl.bSel     = ctrl3.bSel;
        nextCtrl.rd       = ctrl3.rd;
        nextCtrl.immB     = ctrl3.immB;
        nextCtrl.immJ     = ctrl3.immJ;
        nextCtrl.pc       = ctrl3.pc;   // pc goes on for link and targets
        nextCtrl.opA      = rdA;
        nextCtrl.opB      = opB;
        if (redirect.taken) // third squashed slot
        begin
            nextCtrl.we       = 1'b0;
            nextCtrl.isBranch = 1'b0;
            nextCtrl.j        = 1'b0;
            nextCtrl.jr       = 1'b0;
        end
    end

    // pipe #4
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            ctrl4 <= '0;
        else
            ctrl4 <= nextCtrl;
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            nrst,
    input  cpuPkg::wbPort_s wb,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [31:0]     rdA,   // valid one cycle after rs1
    output logic [31:0]     rdB
);

    logic [31:0] regs [32];
    logic [4:0]  addrA;
    logic [4:0]  addrB;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            addrA <= '0;
            addrB <= '0;
        end
        else
        begin
            addrA <= rs1;
            addrB <= rs2;
            if (wb.valid && wb.addr != 5'd0) // x0 stays zero
                regs[wb.addr] <= wb.data;
        end
    end

    // write through so the commit in this cycle is seen at once
    assign rdA = (addrA == 5'd0) ? '0 :
                 (wb.valid && wb.addr == addrA) ? wb.data : regs[addrA];
    assign rdB = (addrB == 5'd0) ? '0 :
                 (wb.valid && wb.addr == addrB) ? wb.data : regs[addrB];

    // decode drops x0 writes before they reach the port
    x0NoWrite: assert property (@(posedge clk) disable iff (!nrst)
        wb.valid |-> wb.addr != 5'd0)
        else $error("write port targets x0 with data %h", wb.data);

endmodule

// ==== design/decodeControl.sv ====
`timescale 1ns/1ns

module decodeControl (
    input  logic                clk,
    input  logic                nrst,
    input  cpuPkg::instrWord_u  instrD,
    input  logic [31:0]         pcD,
    input  cpuPkg::redirect_s   redirect,
    output logic [4:0]          rs1,      // straight from pipe #2 word
    output logic [4:0]          rs2,
    output cpuPkg::issueCtrl_s  ctrl3     // pipe #3
);
    import cpuPkg::*;

    issueCtrl_s nextCtrl;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altFn;   // funct7 bit 5 selects sub and sra
    logic       rdNz;

    assign rs1    = instrD.rFmt.rs1;
    assign rs2    = instrD.rFmt.rs2;
    assign opcode = instrD.rFmt.opcode;
    assign funct3 = instrD.rFmt.funct3;
    assign altFn  = instrD.rFmt.funct7[5];
    assign rdNz   = instrD.rFmt.rd != 5'd0; // x0 never written

    always_comb
    begin
        nextCtrl       = '0;
        nextCtrl.rd    = instrD.rFmt.rd;
        nextCtrl.pc    = pcD;
        nextCtrl.shamt = instrD.iFmt.imm12[4:0];
        nextCtrl.immI  = {{20{instrD.iFmt.imm12[11]}}, instrD.iFmt.imm12};
        nextCtrl.immB  = {{19{instrD.bFmt.imm12}}, instrD.bFmt.imm12, instrD.bFmt.imm11,
                          instrD.bFmt.imm10_5, instrD.bFmt.imm4_1, 1'b0};
        nextCtrl.immJ  = {{11{instrD.jFmt.imm20}}, instrD.jFmt.imm20, instrD.jFmt.imm19_12,
                          instrD.jFmt.imm11, instrD.jFmt.imm10_1, 1'b0};
        nextCtrl.bSel  = bRegB;
        nextCtrl.aluFn = aluAdd;

        // arithmetic and shift ops share one funct3 table
        case (funct3)
            3'b000: nextCtrl.aluFn = (opcode == opOp && altFn) ? aluSub : aluAdd;
            3'b001: nextCtrl.aluFn = aluSll;
            3'b010: nextCtrl.aluFn = aluSlt;
            3'b011: nextCtrl.aluFn = aluSltu;
            3'b100: nextCtrl.aluFn = aluXor;
            3'b101: nextCtrl.aluFn = altFn ? aluSra : aluSrl;
            3'b110: nextCtrl.aluFn = aluOr;
            default: nextCtrl.aluFn = aluAnd;
        endcase

        case (opcode)
            opOp:
                nextCtrl.we = rdNz;
            opOpImm:
            begin
                nextCtrl.we   = rdNz;
                nextCtrl.bSel = (funct3 == 3'b001 || funct3 == 3'b101) ? bShamt : bImmI;
            end
            opLui:
            begin
                nextCtrl.we    = rdNz;
                nextCtrl.aluFn = aluPassB;
                nextCtrl.bSel  = bImmI;
                // upper 20 bits are the raw j view fields in word order
                nextCtrl.immI  = {instrD.jFmt.imm20, instrD.jFmt.imm10_1, instrD.jFmt.imm11,
                                  instrD.jFmt.imm19_12, 12'b0};
            end
            opBranch:
            begin
                if (funct3[2:1] == 2'b00) // beq and bne only
                begin
                    nextCtrl.isBranch = 1'b1;
                    nextCtrl.bneq     = funct3[0];
                end
                else
                    nextCtrl = '0;
            end
            opJal:
            begin
                nextCtrl.we      = rdNz;
                nextCtrl.linkSel = 1'b1;
                nextCtrl.j       = 1'b1;
            end
            opJalr:
            begin
                nextCtrl.we      = rdNz;
                nextCtrl.linkSel = 1'b1;
                nextCtrl.jr      = 1'b1;
                nextCtrl.bSel    = bImmI; // target base+offset goes through opB
            end
            default:
                nextCtrl = '0; // unknown opcode, full bubble
        endcase

        // younger than a taken branch in execute
        if (redirect.taken)
        begin
            nextCtrl.we       = 1'b0;
            nextCtrl.isBranch = 1'b0;
            nextCtrl.j        = 1'b0;
            nextCtrl.jr       = 1'b0;
        end
    end

    // pipe #3
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            ctrl3 <= '0;
        else
            ctrl3 <= nextCtrl;
    end

    flowOneHot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({ctrl3.isBranch, ctrl3.j, ctrl3.jr}))
        else $error("decode raised more than one flow flag");

endmodule

// ==== design/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic                clk,
    input  logic                nrst,
    input  cpuPkg::redirect_s   redirect,
    input  logic [31:0]         instr,     // comb read of instrAddr
    output logic [31:0]         instrAddr,
    output cpuPkg::instrWord_u  instrD,    // pipe #2 word
    output logic [31:0]         pcD        // pipe #2 pc
);
    import cpuPkg::*;

    logic [31:0] pc;
    logic [31:0] pcNext;

    assign instrAddr = pc; // memory answers in the same cycle

    // branch target wins over sequential fetch
    assign pcNext = redirect.taken ? redirect.target : pc + 32'd4;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            pc <= resetPc;
        else
            pc <= pcNext;
    end

    // pipe #2
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            instrD <= nopWord; // bubble
            pcD    <= resetPc;
        end
        else
        begin
            instrD <= redirect.taken ? nopWord : instr; // wrong path word dropped
            pcD    <= pc;
        end
    end

    // target alignment comes from decode immediates and the jalr mask downstream
    pcAligned: assert property (@(posedge clk) disable iff (!nrst) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned %h", pc);

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    // base opcodes of the kept instructions
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    localparam logic [31:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluPassB
    } aluFn_e;

    // operand b source
    typedef enum logic [1:0] {bRegB = 2'd0, bImmI = 2'd1, bShamt = 2'd2} bSel_e;

    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } rFmt_s;

    typedef struct packed {
        logic [11:0] imm12; // shamt sits in [4:0]
        logic [4:0] rs1; logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } iFmt_s;

    typedef struct packed {
        logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
    } bFmt_s;

    typedef struct packed {
        logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
        logic [4:0] rd; logic [6:0] opcode;
    } jFmt_s;

    // one fetched word, four ways to look at it
    typedef union packed {
        rFmt_s rFmt;
        iFmt_s iFmt;
        bFmt_s bFmt;
        jFmt_s jFmt;
    } instrWord_u;

    typedef struct packed {
        logic we; logic linkSel;                     // linkSel picks pc+4 as result
        logic isBranch; logic bneq; logic j; logic jr;
        aluFn_e aluFn; bSel_e bSel; logic [4:0] rd; logic [4:0] shamt;
        logic [31:0] immI; logic [31:0] immB; logic [31:0] immJ;
        logic [31:0] pc;
    } issueCtrl_s;

    typedef struct packed {
        logic we; logic linkSel;
        logic isBranch; logic bneq; logic j; logic jr;
        aluFn_e aluFn; bSel_e bSel; logic [4:0] rd;
        logic [31:0] immB; logic [31:0] immJ; logic [31:0] pc;
        logic [31:0] opA; logic [31:0] opB;
    } exeCtrl_s;

    typedef struct packed {
        logic        taken;  // single cycle pulse
        logic [31:0] target;
    } redirect_s;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbPort_s;

endpackage
